/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu
FILELIST = sim.f

OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Simulation passes only when the pass line shows up in the output
run: build
	./$(BIN) | tee /dev/stderr | grep -Fqx '>>> PASS'

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/apb_pkg.sv */
package apb_pkg;

	typedef logic [3:0] strb_t; // One bit per byte lane

	// Master to slave
	typedef struct packed {
		logic [31:0] paddr;
		logic [31:0] pwdata;
		logic        psel;
		logic        penable;
		logic        pwrite;
		strb_t       pstrb;
	} apb_req_t;

	// Slave to master
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

/* hdl/cpu_alu.sv */
`timescale 1ns/10ps

module cpu_alu (
	input  rv_isa_pkg::alu_op_e op,
	input  rv_isa_pkg::word_t   a,
	input  rv_isa_pkg::word_t   b,
	input  logic [2:0]          funct3,
	output rv_isa_pkg::word_t   result,
	output logic                taken
);

	rv_isa_pkg::word_t sum;
	logic [4:0]        shamt;
	logic              lt_s;
	logic              lt_u;
	logic              eq;

	assign sum   = a + b; // Also the JALR and load/store address
	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;
	assign eq    = (a == b);

	always_comb begin
		case (op)
			rv_isa_pkg::ADD:    result = sum;
			rv_isa_pkg::SUB:    result = a - b;
			rv_isa_pkg::SLL:    result = a << shamt;
			rv_isa_pkg::SLT:    result = {31'b0, lt_s};
			rv_isa_pkg::SLTU:   result = {31'b0, lt_u};
			rv_isa_pkg::XOR:    result = a ^ b;
			rv_isa_pkg::SRL:    result = a >> shamt;
			rv_isa_pkg::SRA:    result = $signed(a) >>> shamt;
			rv_isa_pkg::OR:     result = a | b;
			rv_isa_pkg::AND:    result = a & b;
			rv_isa_pkg::PASS_B: result = b;
			default:            result = sum;
		endcase
	end

	// Branch condition from funct3, a = rs1 and b = rs2
	always_comb begin
		case (funct3)
			3'b000:  taken = eq;    // BEQ
			3'b001:  taken = !eq;   // BNE
			3'b100:  taken = lt_s;  // BLT
			3'b101:  taken = !lt_s; // BGE
			3'b110:  taken = lt_u;  // BLTU
			3'b111:  taken = !lt_u; // BGEU
			default: taken = 1'b0;
		endcase
	end

endmodule

/* hdl/cpu_control.sv */
`timescale 1ns/10ps

module cpu_control (
	input  logic                APB_PCLK,
	input  logic                APB_PRESETn,
	input  logic [6:0]          opcode,
	input  logic [2:0]          funct3,
	input  logic                funct7_5,
	input  logic                taken,
	input  apb_pkg::apb_rsp_t   rsp,
	output rv_isa_pkg::ctl_t    ctl,
	output logic                psel,
	output logic                penable,
	output logic                pwrite,
	output logic                halted,
	output logic                fault
);

	typedef enum logic [2:0] {
		HALT,         // Idle after reset and once halted
		FETCH_SETUP,
		FETCH_ACCESS,
		EXECUTE,
		MEM_SETUP,
		MEM_ACCESS
	} cpu_state_e;

	cpu_state_e          state;
	cpu_state_e          next_state;
	logic                set_halt;
	logic                set_fault;
	logic                is_store;
	logic                is_load;
	logic                mem_ok;
	logic                mem_phase;
	rv_isa_pkg::alu_op_e alu_sel;

	assign is_store  = (opcode == rv_isa_pkg::OP_STORE);
	assign is_load   = (opcode == rv_isa_pkg::OP_LOAD);
	assign mem_ok    = is_load ? (funct3 == 3'b010) : (!funct3[2] && funct3[1:0] != 2'b11);
	assign mem_phase = (state == MEM_SETUP) || (state == MEM_ACCESS);

	assign psel    = (state == FETCH_SETUP) || (state == FETCH_ACCESS) || mem_phase;
	assign penable = (state == FETCH_ACCESS) || (state == MEM_ACCESS);
	assign pwrite  = mem_phase && is_store;

	// ALU operation for OP and OP-IMM
	always_comb begin
		case (funct3)
			3'b000:  alu_sel = (opcode == rv_isa_pkg::OP_REG && funct7_5) ?
			                   rv_isa_pkg::SUB : rv_isa_pkg::ADD; // SUB only in register form
			3'b001:  alu_sel = rv_isa_pkg::SLL;
			3'b010:  alu_sel = rv_isa_pkg::SLT;
			3'b011:  alu_sel = rv_isa_pkg::SLTU;
			3'b100:  alu_sel = rv_isa_pkg::XOR;
			3'b101:  alu_sel = funct7_5 ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
			3'b110:  alu_sel = rv_isa_pkg::OR;
			default: alu_sel = rv_isa_pkg::AND;
		endcase
	end

	always_comb begin
		ctl          = '0;
		ctl.pc_sel   = rv_isa_pkg::PC_PLUS4;
		ctl.imm_sel  = rv_isa_pkg::I;
		ctl.alu_op   = rv_isa_pkg::ADD;
		ctl.wb_sel   = rv_isa_pkg::WB_ALU;
		next_state   = state;
		set_halt     = 1'b0;
		set_fault    = 1'b0;
		if (mem_phase) begin // rs1 + offset held on paddr for the whole transfer
			ctl.b_sel    = 1'b1;
			ctl.imm_sel  = is_store ? rv_isa_pkg::S : rv_isa_pkg::I;
			ctl.addr_sel = 1'b1;
		end
		case (state)
			HALT: if (!halted) next_state = FETCH_SETUP;
			FETCH_SETUP: next_state = FETCH_ACCESS;
			FETCH_ACCESS: if (rsp.pready) begin
				ctl.load_ir = 1'b1;
				if (rsp.pslverr) begin
					{set_halt, set_fault} = 2'b11;
					next_state = HALT;
				end else if (rsp.prdata == '0) begin
					set_halt    = 1'b1;
					ctl.load_pc = 1'b1; // Leaves pc at halt address + 4
					next_state  = HALT;
				end else begin
					next_state = EXECUTE;
				end
			end
			EXECUTE: begin
				ctl.load_pc = 1'b1;
				ctl.reg_we  = 1'b1;
				next_state  = FETCH_SETUP;
				case (opcode)
					rv_isa_pkg::OP_LUI: begin
						{ctl.b_sel, ctl.imm_sel} = {1'b1, rv_isa_pkg::U};
						ctl.alu_op = rv_isa_pkg::PASS_B;
					end
					rv_isa_pkg::OP_AUIPC: begin
						{ctl.a_sel, ctl.b_sel, ctl.imm_sel} = {2'b11, rv_isa_pkg::U};
					end
					rv_isa_pkg::OP_JAL: begin
						ctl.imm_sel = rv_isa_pkg::J;
						ctl.pc_sel  = rv_isa_pkg::PC_TARGET;
						ctl.wb_sel  = rv_isa_pkg::WB_PC4; // Link
					end
					rv_isa_pkg::OP_JALR: begin
						ctl.b_sel  = 1'b1;
						ctl.pc_sel = rv_isa_pkg::PC_JALR;
						ctl.wb_sel = rv_isa_pkg::WB_PC4;
					end
					rv_isa_pkg::OP_BRANCH: begin
						ctl.reg_we  = 1'b0;
						ctl.imm_sel = rv_isa_pkg::B;
						if (taken) ctl.pc_sel = rv_isa_pkg::PC_TARGET;
					end
					rv_isa_pkg::OP_IMM: {ctl.b_sel, ctl.alu_op} = {1'b1, alu_sel};
					rv_isa_pkg::OP_REG: ctl.alu_op = alu_sel;
					rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_STORE: begin
						{ctl.load_pc, ctl.reg_we} = 2'b00; // Finished in MEM_ACCESS
						if (mem_ok) begin
							next_state = MEM_SETUP;
						end else begin
							{set_halt, set_fault} = 2'b11;
							next_state = HALT;
						end
					end
					default: begin // Unsupported opcode
						{ctl.load_pc, ctl.reg_we} = 2'b00;
						{set_halt, set_fault} = 2'b11;
						next_state = HALT;
					end
				endcase
			end
			MEM_SETUP: next_state = MEM_ACCESS;
			MEM_ACCESS: if (rsp.pready) begin
				if (rsp.pslverr) begin
					{set_halt, set_fault} = 2'b11;
					next_state = HALT;
				end else begin
					ctl.load_pc = 1'b1;
					ctl.reg_we  = is_load; // LW writeback
					ctl.wb_sel  = rv_isa_pkg::WB_MEM;
					next_state  = FETCH_SETUP;
				end
			end
			default: next_state = HALT;
		endcase
	end

	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			state  <= HALT;
			halted <= 1'b0;
			fault  <= 1'b0;
		end else begin
			state <= next_state;
			if (set_halt) halted <= 1'b1; // Sticky until reset
			if (set_fault) fault <= 1'b1;
		end
	end

	a_penable_psel: assert property (
		@(posedge APB_PCLK) disable iff (!APB_PRESETn) penable |-> psel
	) else $error("penable without psel");

	a_halt_idle: assert property (
		@(posedge APB_PCLK) disable iff (!APB_PRESETn) halted |-> !psel && !penable
	) else $error("Bus active while halted");

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/10ps

module cpu_core #(
	parameter rv_isa_pkg::word_t RESET_PC = 32'h0
) (
	input  logic              APB_PCLK,
	input  logic              APB_PRESETn,
	output apb_pkg::apb_req_t apb_req,
	input  apb_pkg::apb_rsp_t apb_rsp,
	output logic              halted,
	output logic              fault,
	output rv_isa_pkg::word_t pc
);

	rv_isa_pkg::ctl_t      ctl;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic                  funct7_5;
	logic                  taken;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	rv_isa_pkg::word_t     alu_a;
	rv_isa_pkg::word_t     alu_b;
	rv_isa_pkg::word_t     alu_result;
	rv_isa_pkg::word_t     rs1_data;
	rv_isa_pkg::word_t     rs2_data;
	rv_isa_pkg::word_t     rd_data;
	rv_isa_pkg::reg_addr_t rs1_addr;
	rv_isa_pkg::reg_addr_t rs2_addr;
	rv_isa_pkg::reg_addr_t rd_addr;
	rv_isa_pkg::word_t     paddr;
	rv_isa_pkg::word_t     pwdata;
	apb_pkg::strb_t        pstrb;

	// Phase bits from control, address and data from the datapath
	assign apb_req = '{paddr: paddr, pwdata: pwdata, psel: psel,
	                   penable: penable, pwrite: pwrite, pstrb: pstrb};

	cpu_control u_control (
		.APB_PCLK, .APB_PRESETn, .opcode, .funct3, .funct7_5, .taken,
		.rsp(apb_rsp), .ctl, .psel, .penable, .pwrite, .halted, .fault
	);

	cpu_datapath #(.RESET_PC(RESET_PC)) u_datapath (
		.APB_PCLK, .APB_PRESETn, .ctl, .prdata(apb_rsp.prdata),
		.rs1_data, .rs2_data, .alu_result, .alu_a, .alu_b, .rd_data,
		.rs1_addr, .rs2_addr, .rd_addr, .opcode, .funct3, .funct7_5,
		.paddr, .pwdata, .pstrb, .pc
	);

	cpu_alu u_alu (
		.op(ctl.alu_op), .a(alu_a), .b(alu_b), .funct3, .result(alu_result), .taken
	);

	cpu_regfile u_regfile (
		.APB_PCLK, .we(ctl.reg_we), .wa(rd_addr), .wd(rd_data),
		.ra0(rs1_addr), .ra1(rs2_addr), .rd0(rs1_data), .rd1(rs2_data)
	);

endmodule

/* hdl/cpu_datapath.sv */
`timescale 1ns/10ps

module cpu_datapath #(
	parameter rv_isa_pkg::word_t RESET_PC = 32'h0
) (
	input  logic                  APB_PCLK,
	input  logic                  APB_PRESETn,
	input  rv_isa_pkg::ctl_t      ctl,
	input  rv_isa_pkg::word_t     prdata,
	input  rv_isa_pkg::word_t     rs1_data,
	input  rv_isa_pkg::word_t     rs2_data,
	input  rv_isa_pkg::word_t     alu_result,
	output rv_isa_pkg::word_t     alu_a,
	output rv_isa_pkg::word_t     alu_b,
	output rv_isa_pkg::word_t     rd_data,
	output rv_isa_pkg::reg_addr_t rs1_addr,
	output rv_isa_pkg::reg_addr_t rs2_addr,
	output rv_isa_pkg::reg_addr_t rd_addr,
	output logic [6:0]            opcode,
	output logic [2:0]            funct3,
	output logic                  funct7_5,
	output rv_isa_pkg::word_t     paddr,
	output rv_isa_pkg::word_t     pwdata,
	output apb_pkg::strb_t        pstrb,
	output rv_isa_pkg::word_t     pc
);

	rv_isa_pkg::word_t ir;
	rv_isa_pkg::word_t imm;
	rv_isa_pkg::word_t pc_plus4;
	rv_isa_pkg::word_t next_pc;
	logic [1:0]        lane;
	apb_pkg::strb_t    st_strb;

	assign opcode   = ir[6:0];
	assign funct3   = ir[14:12];
	assign funct7_5 = ir[30];
	assign rd_addr  = ir[11:7];
	assign rs1_addr = ir[19:15];
	assign rs2_addr = ir[24:20];

	always_comb begin
		case (ctl.imm_sel)
			rv_isa_pkg::S: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			rv_isa_pkg::B: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			rv_isa_pkg::U: imm = {ir[31:12], 12'b0};
			rv_isa_pkg::J: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			default:       imm = {{20{ir[31]}}, ir[31:20]}; // I format
		endcase
	end

	assign alu_a    = ctl.a_sel ? pc : rs1_data;
	assign alu_b    = ctl.b_sel ? imm : rs2_data;
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		case (ctl.wb_sel)
			rv_isa_pkg::WB_PC4: rd_data = pc_plus4;
			rv_isa_pkg::WB_MEM: rd_data = prdata;
			default:            rd_data = alu_result;
		endcase
		case (ctl.pc_sel)
			rv_isa_pkg::PC_TARGET: next_pc = pc + imm; // Separate from the ALU
			rv_isa_pkg::PC_JALR:   next_pc = {alu_result[31:1], 1'b0};
			default:               next_pc = pc_plus4;
		endcase
	end

	// Store lane and strobe, SH keeps to halfword boundaries
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				lane    = alu_result[1:0];
				st_strb = 4'b0001 << lane;
			end
			2'b01: begin
				lane    = {alu_result[1], 1'b0};
				st_strb = 4'b0011 << lane;
			end
			default: begin
				lane    = 2'b00;
				st_strb = 4'b1111;
			end
		endcase
	end

	assign paddr  = ctl.addr_sel ? {alu_result[31:2], 2'b00} : pc;
	assign pwdata = rs2_data << {lane, 3'b000};
	assign pstrb  = (ctl.addr_sel && opcode == rv_isa_pkg::OP_STORE) ? st_strb : 4'b1111;

	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			pc <= RESET_PC;
		end else if (ctl.load_pc) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge APB_PCLK) begin
		if (ctl.load_ir) ir <= prdata;
	end

	a_pc_aligned: assert property (
		@(posedge APB_PCLK) disable iff (!APB_PRESETn) pc[1:0] == 2'b00
	) else $error("pc not word aligned");

endmodule

/* hdl/cpu_regfile.sv */
`timescale 1ns/10ps

module cpu_regfile (
	input  logic                  APB_PCLK,
	input  logic                  we,
	input  rv_isa_pkg::reg_addr_t wa,
	input  rv_isa_pkg::word_t     wd,
	input  rv_isa_pkg::reg_addr_t ra0,
	input  rv_isa_pkg::reg_addr_t ra1,
	output rv_isa_pkg::word_t     rd0,
	output rv_isa_pkg::word_t     rd1
);

	rv_isa_pkg::word_t regs [32];

	always_ff @(posedge APB_PCLK) begin
		if (we && wa != '0) begin // x0 stays zero
			regs[wa] <= wd;
		end
	end

	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

	// Control must hand over a valid destination with every write
	a_wa_known: assert property (
		@(posedge APB_PCLK) we |-> !$isunknown(wa)
	) else $error("Register write with unknown address");

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

	typedef logic [31:0] word_t; // Data word or byte address
	typedef logic [4:0]  reg_addr_t; // Register index x0..x31

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		PASS_B // Forward operand b, used by LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		I, S, B, U, J
	} imm_sel_e;

	typedef enum logic [1:0] {
		PC_PLUS4,  // Sequential
		PC_TARGET, // pc + immediate, branch and JAL
		PC_JALR    // ALU sum with bit 0 cleared
	} pc_sel_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_PC4, WB_MEM
	} wb_sel_e;

	typedef struct packed {
		logic     load_ir;
		logic     load_pc;
		pc_sel_e  pc_sel;
		logic     a_sel;    // 1 selects pc
		logic     b_sel;    // 1 selects immediate
		imm_sel_e imm_sel;
		alu_op_e  alu_op;
		logic     reg_we;
		wb_sel_e  wb_sel;
		logic     addr_sel; // 1 selects ALU result as bus address
	} ctl_t;

endpackage

/* sim.f */
hdl/rv_isa_pkg.sv
hdl/apb_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_regfile.sv
hdl/cpu_control.sv
hdl/cpu_datapath.sv
hdl/cpu_core.sv
test/tb_apb_mem.sv
test/tb_cpu.sv

/* test/tb_apb_mem.sv */
`timescale 1ns/10ps

module tb_apb_mem #(
	parameter int          WORDS    = 1024,
	parameter logic [31:0] ERR_BASE = 32'h0000_1000
) (
	input  logic              APB_PCLK,
	input  logic              APB_PRESETn,
	input  apb_pkg::apb_req_t req,
	output apb_pkg::apb_rsp_t rsp
);

	logic [31:0] mem [WORDS];
	logic [1:0]  wait_cnt;  // Wait states left in the access phase
	logic        ready;
	logic        err;
	logic [9:0]  idx;
	integer      seed;

	initial seed = 45971;

	assign idx   = req.paddr[11:2];
	assign err   = (req.paddr >= ERR_BASE);
	assign ready = req.psel && req.penable && (wait_cnt == 2'd0);

	assign rsp = '{prdata: mem[idx], pready: ready, pslverr: ready && err};

	// New wait count picked in every setup cycle
	always @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			wait_cnt <= 2'd0;
		end else if (req.psel && !req.penable) begin
			wait_cnt <= 2'($random(seed));
		end else if (wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end
	end

	always @(posedge APB_PCLK) begin
		if (ready && req.pwrite && !err) begin
			for (int b = 0; b < 4; b++) begin
				if (req.pstrb[b]) mem[idx][b*8 +: 8] = req.pwdata[b*8 +: 8]; // Byte lanes
			end
		end
	end

endmodule

/* test/tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

	logic              APB_PCLK;
	logic              APB_PRESETn;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;
	logic              halted;
	logic              fault;
	logic [31:0]       pc;

	string       row_name [24];
	logic [31:0] row_prog [24][20];
	int          row_len [24];
	logic [31:0] row_addr [24];
	logic [31:0] row_exp [24];
	logic        row_fault [24];
	logic [31:0] row_pc [24];
	int          n_rows = 0;
	logic [31:0] prog_q [$];
	int          cycles = 0;
	int          limit = 100000;

	cpu_core #(.RESET_PC(32'h0)) uut (
		.APB_PCLK, .APB_PRESETn, .apb_req, .apb_rsp, .halted, .fault, .pc
	);

	tb_apb_mem slave (.APB_PCLK, .APB_PRESETn, .req(apb_req), .rsp(apb_rsp));

	initial begin
		APB_PCLK = 1'b0;
		forever #2 APB_PCLK = ~APB_PCLK;
	end

	always @(posedge APB_PCLK) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: core did not halt within %0d cycles", limit);
			$display(">>> FAIL");
			$fatal(1);
		end
	end

	// Instruction encoders
	function automatic logic [31:0] i_type(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
	                                       logic [4:0] rd, logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3);
		return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33}; // x3 = x1 op x2
	endfunction

	function automatic logic [31:0] s_type(logic [31:0] imm, logic [4:0] rs2, logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23}; // Base is x0
	endfunction

	function automatic logic [31:0] b_type(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
	                                       logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] j_type(logic [31:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] add_reg(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
		return {7'h00, rs2, rs1, 3'd0, rd, 7'h33};
	endfunction

	function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
		return i_type(imm, rs1, 3'd0, rd, 7'h13);
	endfunction

	// stop_idx < 0 means the run ends on the final zero word
	task automatic commit_row(string name, logic [31:0] addr, logic [31:0] exp,
	                          logic flt, int stop_idx);
		int last;
		last = (stop_idx < 0) ? prog_q.size() - 1 : stop_idx;
		row_name[n_rows]  = name;
		row_len[n_rows]   = prog_q.size();
		row_addr[n_rows]  = addr;
		row_exp[n_rows]   = exp;
		row_fault[n_rows] = flt;
		row_pc[n_rows]    = flt ? 32'(last * 4) : 32'(last * 4 + 4);
		foreach (prog_q[i]) row_prog[n_rows][i] = prog_q[i];
		prog_q.delete();
		n_rows++;
	endtask

	// x1 = -7, x2 = 3, result in x3
	task automatic alu_row(string name, logic [31:0] instr, logic [31:0] exp);
		prog_q = {addi(1, 0, -7), addi(2, 0, 3), instr, s_type(32'h100, 3, 3'd2), 32'h0};
		commit_row(name, 32'h100, exp, 1'b0, -1);
	endtask

	// Preset word 0x11223344 at 0x100, x2 = 0xAB, x3 = 0x7EE
	task automatic store_row(string name, logic [31:0] s1, logic [31:0] s2, logic [31:0] exp);
		prog_q = {u_type(20'h11223, 1, 7'h37), addi(1, 1, 32'h344), s_type(32'h100, 1, 3'd2),
		          addi(2, 0, 32'hAB), addi(3, 0, 32'h7EE), s1, s2,
		          i_type(32'h100, 0, 3'd2, 5, 7'h03), s_type(32'h104, 5, 3'd2), 32'h0};
		commit_row(name, 32'h104, exp, 1'b0, -1);
	endtask

	task automatic build_table();
		alu_row("add", r_type(7'h00, 3'd0), 32'hFFFF_FFFC);
		alu_row("sub", r_type(7'h20, 3'd0), 32'hFFFF_FFF6);
		alu_row("xor", r_type(7'h00, 3'd4), 32'hFFFF_FFFA);
		alu_row("or", r_type(7'h00, 3'd6), 32'hFFFF_FFFB);
		alu_row("and", r_type(7'h00, 3'd7), 32'h0000_0001);
		alu_row("sll", r_type(7'h00, 3'd1), 32'hFFFF_FFC8);
		alu_row("srl", r_type(7'h00, 3'd5), 32'h1FFF_FFFF);
		alu_row("sra", r_type(7'h20, 3'd5), 32'hFFFF_FFFF);
		alu_row("slt", r_type(7'h00, 3'd2), 32'h0000_0001);
		alu_row("sltu", r_type(7'h00, 3'd3), 32'h0000_0000);
		alu_row("slti", i_type(-6, 1, 3'd2, 3, 7'h13), 32'h0000_0001);
		alu_row("sltiu", i_type(3, 1, 3'd3, 3, 7'h13), 32'h0000_0000);
		alu_row("srai", i_type(32'h401, 1, 3'd5, 3, 7'h13), 32'hFFFF_FFFC);
		alu_row("andi", i_type(32'h0F0, 1, 3'd7, 3, 7'h13), 32'h0000_00F0);
		prog_q = {u_type(20'h12345, 3, 7'h37), s_type(32'h100, 3, 3'd2), 32'h0};
		commit_row("lui", 32'h100, 32'h1234_5000, 1'b0, -1);
		prog_q = {addi(0, 0, 0), u_type(20'h00001, 3, 7'h17), s_type(32'h100, 3, 3'd2), 32'h0};
		commit_row("auipc", 32'h100, 32'h0000_1004, 1'b0, -1);
		// Marker bits 1, 4, 16 and 32 sit on skipped paths
		prog_q = {addi(4, 0, 0), addi(1, 0, 5), addi(2, 0, -1),
		          b_type(8, 1, 1, 3'd0), addi(4, 4, 1), b_type(8, 1, 1, 3'd1), addi(4, 4, 2),
		          b_type(8, 1, 2, 3'd4), addi(4, 4, 4), b_type(8, 1, 2, 3'd6), addi(4, 4, 8),
		          b_type(8, 2, 1, 3'd5), addi(4, 4, 16), b_type(8, 1, 2, 3'd7), addi(4, 4, 32),
		          s_type(32'h100, 4, 3'd2), 32'h0};
		commit_row("branch", 32'h100, 32'h0000_000A, 1'b0, -1);
		// Links 8 and 20 are summed
		// JALR target 27 + 2 with bit 0 cleared
		prog_q = {addi(4, 0, 0), j_type(8, 5), addi(4, 4, 1), addi(6, 0, 27),
		          i_type(2, 6, 3'd0, 7, 7'h67), addi(4, 4, 2), addi(4, 4, 4),
		          add_reg(4, 4, 5), add_reg(4, 4, 7),
		          s_type(32'h100, 4, 3'd2), 32'h0};
		commit_row("jump", 32'h100, 32'h0000_001C, 1'b0, -1);
		store_row("sb0_sb3", s_type(32'h100, 2, 3'd0), s_type(32'h103, 2, 3'd0), 32'hAB22_33AB);
		store_row("sb1_sh2", s_type(32'h101, 2, 3'd0), s_type(32'h102, 3, 3'd1), 32'h07EE_AB44);
		store_row("sh0_sb2", s_type(32'h100, 3, 3'd1), s_type(32'h102, 2, 3'd0), 32'h11AB_07EE);
		prog_q = {addi(3, 0, 32'h55), s_type(32'h100, 3, 3'd2), 32'hFFFF_FFFF, 32'h0};
		commit_row("illegal", 32'h100, 32'h0000_0055, 1'b1, 2);
		prog_q = {u_type(20'h00001, 1, 7'h37), addi(3, 0, 32'h66), s_type(32'h100, 3, 3'd2),
		          i_type(0, 1, 3'd2, 2, 7'h03), s_type(32'h100, 0, 3'd2), 32'h0};
		commit_row("load_err", 32'h100, 32'h0000_0066, 1'b1, 3);
	endtask

	task automatic check_equal(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	initial begin
		int total;
		APB_PRESETn = 1'b0;
		build_table();
		total = 0;
		for (int r = 0; r < n_rows; r++) total += row_len[r];
		limit = total * (5 + 2 * 3) + n_rows * 8 + 200; // Two bus phases of up to 3 waits
		for (int r = 0; r < n_rows; r++) begin
			@(posedge APB_PCLK);
			#1 APB_PRESETn = 1'b0;
			for (int i = 0; i < 1024; i++) slave.mem[i] = 32'h5A00_0000 ^ (i * 4 + 32'h1357);
			for (int i = 0; i < row_len[r]; i++) slave.mem[i] = row_prog[r][i];
			repeat (5) @(posedge APB_PCLK);
			#1 APB_PRESETn = 1'b1;
			do begin
				@(posedge APB_PCLK);
				#1;
			end while (!halted);
			repeat (2) @(posedge APB_PCLK);
			#1;
			check_equal({row_name[r], " result"}, row_exp[r], slave.mem[row_addr[r][11:2]]);
			check_equal({row_name[r], " halted"}, 32'd1, {31'd0, halted});
			check_equal({row_name[r], " fault"}, {31'd0, row_fault[r]}, {31'd0, fault});
			check_equal({row_name[r], " psel"}, 32'd0, {31'd0, apb_req.psel});
			check_equal({row_name[r], " pc"}, row_pc[r], pc);
		end
		$display(">>> PASS");
		$finish;
	end

endmodule
